//--- include/ili_consts.svh
`ifndef ILI_CONSTS_SVH
`define ILI_CONSTS_SVH

// ------------------------------------------------------------
// Word and pixel widths
// ------------------------------------------------------------
`define ILI_BYTE_W      8           // Bits per SPI byte
`define ILI_PIXEL_W     16          // RGB565 pixel

// ------------------------------------------------------------
// Power-up sequence
// ------------------------------------------------------------
`define ILI_INIT_LEN    83          // Words in the init table
`define ILI_WAIT_100MS  2500000     // 100 ms at 25 MHz

// ------------------------------------------------------------
// SPI link timing
// ------------------------------------------------------------
`define ILI_SCK_HALF    1           // clk cycles per sck half period

// ------------------------------------------------------------
// Drawing window and orientation
// ------------------------------------------------------------
`define ILI_COL_END     239         // Last column
`define ILI_PAGE_END    319         // Last page
`define ILI_MADCTL_VAL  8'h48       // MX plus BGR

`endif

//--- logic/ili_pkg.sv
`include "ili_consts.svh"

package ili_pkg;

    // One word on the LCD link
    typedef struct packed {
        logic                   dc;     // 0 command, 1 data
        logic [`ILI_BYTE_W-1:0] data;
    } lcd_word_t;

    // Commands this controller sends
    typedef enum logic [`ILI_BYTE_W-1:0] {
        SWRESET   = 8'h01,
        SLPOUT    = 8'h11,
        GAMMASET  = 8'h26,
        DISPON    = 8'h29,
        CASET     = 8'h2A,
        PASET     = 8'h2B,
        RAMWR     = 8'h2C,
        MADCTL    = 8'h36,
        VSCRADD   = 8'h37,
        PIXFMT    = 8'h3A,
        FRMCTR1   = 8'hB1,
        DFUNCTR   = 8'hB6,
        PWCTR1    = 8'hC0,
        PWCTR2    = 8'hC1,
        VMCTR1    = 8'hC5,
        VMCTR2    = 8'hC7,
        POWERA    = 8'hCB,
        POWERB    = 8'hCF,
        GMCTRP1   = 8'hE0,
        GMCTRN1   = 8'hE1,
        DTCA      = 8'hE8,
        DTCB      = 8'hEA,
        POWER_SEQ = 8'hED,
        GAMMA3_EN = 8'hF2,
        PRC       = 8'hF7
    } ili_cmd_e;

    typedef enum logic [3:0] {
        START,
        SEND_RESET,
        WAIT_RESET,
        SEND_INIT,
        WAIT_INIT,
        DISPLAY_ON,
        WAIT_ON,
        SET_ROTATION,
        SET_WINDOW,
        PIXEL_HIGH,
        PIXEL_LOW,
        FRAME_PAUSE
    } seq_state_e;

endpackage

//--- logic/ili_word_if.sv
`timescale 1ns/100ps

interface ili_word_if;

    ili_pkg::lcd_word_t word;       // Valid while send is high
    logic               send;       // One-cycle strobe
    logic               idle;       // Master ready for a word
    logic               busy_dc;    // dc of the byte on the wire

    modport source (
        output word,
        output send,
        input  idle
    );

    modport sink (
        input  word,
        input  send,
        output idle,
        output busy_dc
    );

endinterface

//--- logic/ili_init_rom.sv
`timescale 1ns/100ps
`include "ili_consts.svh"

module ili_init_rom (
    input  logic [$clog2(`ILI_INIT_LEN)-1:0] index,
    output ili_pkg::lcd_word_t               word
);

    always_comb begin
        case (index)
            7'd0:  word = {1'b0, ili_pkg::POWERA};
            7'd1:  word = {1'b1, 8'h39};
            7'd2:  word = {1'b1, 8'h2C};
            7'd3:  word = {1'b1, 8'h00};
            7'd4:  word = {1'b1, 8'h34};
            7'd5:  word = {1'b1, 8'h02};          // Vcore 1.6 V, DDVDH 5.6 V
            7'd6:  word = {1'b0, ili_pkg::POWERB};
            7'd7:  word = {1'b1, 8'h00};
            7'd8:  word = {1'b1, 8'hC1};
            7'd9:  word = {1'b1, 8'h30};
            7'd10: word = {1'b0, ili_pkg::DTCA};
            7'd11: word = {1'b1, 8'h85};
            7'd12: word = {1'b1, 8'h00};
            7'd13: word = {1'b1, 8'h78};
            7'd14: word = {1'b0, ili_pkg::DTCB};
            7'd15: word = {1'b1, 8'h00};
            7'd16: word = {1'b1, 8'h00};
            7'd17: word = {1'b0, ili_pkg::POWER_SEQ};
            7'd18: word = {1'b1, 8'h64};
            7'd19: word = {1'b1, 8'h03};
            7'd20: word = {1'b1, 8'h12};
            7'd21: word = {1'b1, 8'h81};
            7'd22: word = {1'b0, ili_pkg::PRC};
            7'd23: word = {1'b1, 8'h20};          // DDVDH = 2 x VCI
            7'd24: word = {1'b0, ili_pkg::PWCTR1};
            7'd25: word = {1'b1, 8'h23};          // GVDD 4.6 V
            7'd26: word = {1'b0, ili_pkg::PWCTR2};
            7'd27: word = {1'b1, 8'h10};
            7'd28: word = {1'b0, ili_pkg::VMCTR1};
            7'd29: word = {1'b1, 8'h3E};
            7'd30: word = {1'b1, 8'h28};
            7'd31: word = {1'b0, ili_pkg::VMCTR2};
            7'd32: word = {1'b1, 8'h86};
            7'd33: word = {1'b0, ili_pkg::MADCTL};
            7'd34: word = {1'b1, 8'h48};
            7'd35: word = {1'b0, ili_pkg::VSCRADD};
            7'd36: word = {1'b1, 8'h00};
            7'd37: word = {1'b0, ili_pkg::PIXFMT};
            7'd38: word = {1'b1, 8'h55};          // 16 bits per pixel
            7'd39: word = {1'b0, ili_pkg::FRMCTR1};
            7'd40: word = {1'b1, 8'h00};
            7'd41: word = {1'b1, 8'h18};          // 79 Hz frame rate
            7'd42: word = {1'b0, ili_pkg::DFUNCTR};
            7'd43: word = {1'b1, 8'h08};
            7'd44: word = {1'b1, 8'h82};
            7'd45: word = {1'b1, 8'h27};
            7'd46: word = {1'b0, ili_pkg::GAMMA3_EN};
            7'd47: word = {1'b1, 8'h00};
            7'd48: word = {1'b0, ili_pkg::GAMMASET};
            7'd49: word = {1'b1, 8'h01};
            7'd50: word = {1'b0, ili_pkg::GMCTRP1};
            7'd51: word = {1'b1, 8'h0F};
            7'd52: word = {1'b1, 8'h31};
            7'd53: word = {1'b1, 8'h2B};
            7'd54: word = {1'b1, 8'h0C};
            7'd55: word = {1'b1, 8'h0E};
            7'd56: word = {1'b1, 8'h08};
            7'd57: word = {1'b1, 8'h4E};
            7'd58: word = {1'b1, 8'hF1};
            7'd59: word = {1'b1, 8'h37};
            7'd60: word = {1'b1, 8'h07};
            7'd61: word = {1'b1, 8'h10};
            7'd62: word = {1'b1, 8'h03};
            7'd63: word = {1'b1, 8'h0E};
            7'd64: word = {1'b1, 8'h09};
            7'd65: word = {1'b1, 8'h00};
            7'd66: word = {1'b0, ili_pkg::GMCTRN1};
            7'd67: word = {1'b1, 8'h00};
            7'd68: word = {1'b1, 8'h0E};
            7'd69: word = {1'b1, 8'h14};
            7'd70: word = {1'b1, 8'h03};
            7'd71: word = {1'b1, 8'h11};
            7'd72: word = {1'b1, 8'h07};
            7'd73: word = {1'b1, 8'h31};
            7'd74: word = {1'b1, 8'hC1};
            7'd75: word = {1'b1, 8'h48};
            7'd76: word = {1'b1, 8'h08};
            7'd77: word = {1'b1, 8'h0F};
            7'd78: word = {1'b1, 8'h0C};
            7'd79: word = {1'b1, 8'h31};
            7'd80: word = {1'b1, 8'h36};
            7'd81: word = {1'b1, 8'h0F};
            7'd82: word = {1'b0, ili_pkg::SLPOUT};  // Last entry
            default: word = {1'b0, 8'h00};
        endcase
    end

endmodule

//--- logic/ili_spi_master.sv
`timescale 1ns/100ps
`include "ili_consts.svh"

module ili_spi_master (
    input  logic       clk,
    input  logic       rst,
    output logic       spi_mosi,
    output logic       spi_sck,
    output logic       spi_cs,
    output logic       spi_dc,
    ili_word_if.sink   word_bus
);

    localparam int PH_W      = $clog2(`ILI_SCK_HALF + 1);
    localparam int HALF_LAST = 2 * `ILI_BYTE_W;   // Final half period holds cs low

    logic                   cs_q;
    logic                   sck_q;
    logic                   dc_q;
    logic [PH_W-1:0]        ph;                   // clk count inside a half period
    logic [4:0]             hcnt;                 // Half periods done
    logic [`ILI_BYTE_W-1:0] shift_q;
    logic                   half_end;

    assign half_end = (ph == PH_W'(`ILI_SCK_HALF - 1));

    // ------------------------------------------------------------
    // Frame control
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            cs_q  <= 1'b1;
            sck_q <= 1'b0;
            dc_q  <= 1'b0;
            ph    <= '0;
            hcnt  <= '0;
        end else if (cs_q) begin
            if (word_bus.send) begin
                cs_q <= 1'b0;                     // Start of byte
                dc_q <= word_bus.word.dc;
                ph   <= '0;
                hcnt <= '0;
            end
        end else if (half_end) begin
            ph   <= '0;
            hcnt <= hcnt + 5'd1;
            if (hcnt == 5'(HALF_LAST)) begin
                cs_q <= 1'b1;
            end else begin
                sck_q <= ~sck_q;
            end
        end else begin
            ph <= ph + PH_W'(1);
        end
    end

    // Data shifts on the falling sck edge, MSB first
    always_ff @(posedge clk) begin
        if (cs_q && word_bus.send) begin
            shift_q <= word_bus.word.data;
        end else if (!cs_q && half_end && sck_q) begin
            shift_q <= {shift_q[`ILI_BYTE_W-2:0], 1'b0};
        end
    end

    assign spi_mosi         = shift_q[`ILI_BYTE_W-1] & ~cs_q;
    assign spi_sck          = sck_q;
    assign spi_cs           = cs_q;
    assign word_bus.idle    = cs_q;
    assign word_bus.busy_dc = dc_q;
    assign spi_dc           = word_bus.busy_dc;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_sck_idle_low: assert property (@(posedge clk) disable iff (!rst)
        spi_cs |-> !spi_sck);

    a_no_send_busy: assert property (@(posedge clk) disable iff (!rst)
        !cs_q |-> !word_bus.send);

endmodule

//--- logic/ili_sequencer.sv
`timescale 1ns/100ps
`include "ili_consts.svh"

module ili_sequencer #(
    parameter int unsigned wait_cycles = `ILI_WAIT_100MS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ILI_PIXEL_W-1:0] input_data,
    input  logic                    frame_done,
    output logic                    data_clk,
    ili_word_if.source              word_bus
);

    localparam int IDX_W = $clog2(`ILI_INIT_LEN);
    localparam int DLY_W = $clog2(wait_cycles + 1);
    localparam logic [15:0] COL_END  = `ILI_COL_END;
    localparam logic [15:0] PAGE_END = `ILI_PAGE_END;

    ili_pkg::seq_state_e     state;
    logic [IDX_W-1:0]        step;               // Table index or setup step
    logic [DLY_W-1:0]        dly;
    logic [`ILI_BYTE_W-1:0]  pixel_q;
    logic                    in_wait;
    logic                    wait_done;
    logic                    sending;
    logic                    fire;
    ili_pkg::lcd_word_t      rom_word;
    ili_pkg::lcd_word_t      win_word;

    ili_init_rom ili_init_rom_i (
        .index (step),
        .word  (rom_word)
    );

    // ------------------------------------------------------------
    // Word selection
    // ------------------------------------------------------------
    always_comb begin
        case (step[3:0])
            4'd0:    win_word = {1'b0, ili_pkg::CASET};
            4'd1:    win_word = {1'b1, 8'h00};    // Start column
            4'd2:    win_word = {1'b1, 8'h00};
            4'd3:    win_word = {1'b1, COL_END[15:8]};
            4'd4:    win_word = {1'b1, COL_END[7:0]};
            4'd5:    win_word = {1'b0, ili_pkg::PASET};
            4'd6:    win_word = {1'b1, 8'h00};    // Start page
            4'd7:    win_word = {1'b1, 8'h00};
            4'd8:    win_word = {1'b1, PAGE_END[15:8]};
            4'd9:    win_word = {1'b1, PAGE_END[7:0]};
            default: win_word = {1'b0, ili_pkg::RAMWR};
        endcase
    end

    always_comb begin
        case (state)
            ili_pkg::SEND_RESET:   word_bus.word = {1'b0, ili_pkg::SWRESET};
            ili_pkg::SEND_INIT:    word_bus.word = rom_word;
            ili_pkg::DISPLAY_ON:   word_bus.word = {1'b0, ili_pkg::DISPON};
            ili_pkg::SET_ROTATION: word_bus.word = step[0] ? {1'b1, `ILI_MADCTL_VAL}
                                                           : {1'b0, ili_pkg::MADCTL};
            ili_pkg::SET_WINDOW:   word_bus.word = win_word;
            ili_pkg::PIXEL_HIGH:   word_bus.word = {1'b1, input_data[15:8]};
            ili_pkg::PIXEL_LOW:    word_bus.word = {1'b1, pixel_q};
            default:               word_bus.word = {1'b0, 8'h00};
        endcase
    end

    assign sending = state inside {ili_pkg::SEND_RESET, ili_pkg::SEND_INIT,
                                   ili_pkg::DISPLAY_ON, ili_pkg::SET_ROTATION,
                                   ili_pkg::SET_WINDOW, ili_pkg::PIXEL_HIGH,
                                   ili_pkg::PIXEL_LOW};
    assign fire          = sending && word_bus.idle;
    assign word_bus.send = fire;
    assign data_clk      = (state == ili_pkg::PIXEL_HIGH) && word_bus.idle;

    // Low byte kept for PIXEL_LOW
    always_ff @(posedge clk) begin
        if (data_clk) begin
            pixel_q <= input_data[`ILI_BYTE_W-1:0];
        end
    end

    // ------------------------------------------------------------
    // Delay counter
    // ------------------------------------------------------------
    assign in_wait   = state inside {ili_pkg::WAIT_RESET, ili_pkg::WAIT_INIT,
                                     ili_pkg::WAIT_ON};
    assign wait_done = in_wait && word_bus.idle && (dly == DLY_W'(wait_cycles - 1));

    always_ff @(posedge clk) begin
        if (!rst || !in_wait || wait_done) begin
            dly <= '0;
        end else if (word_bus.idle) begin
            dly <= dly + DLY_W'(1);               // Counts once the last byte is out
        end
    end

    // ------------------------------------------------------------
    // Power-up and streaming FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ili_pkg::START;
            step  <= '0;
        end else begin
            case (state)
                ili_pkg::START:      state <= ili_pkg::SEND_RESET;
                ili_pkg::SEND_RESET: if (fire) state <= ili_pkg::WAIT_RESET;
                ili_pkg::WAIT_RESET: if (wait_done) state <= ili_pkg::SEND_INIT;
                ili_pkg::SEND_INIT: begin
                    if (fire) begin
                        if (step == IDX_W'(`ILI_INIT_LEN - 1)) begin
                            step  <= '0;
                            state <= ili_pkg::WAIT_INIT;
                        end else begin
                            step <= step + IDX_W'(1);
                        end
                    end
                end
                ili_pkg::WAIT_INIT:  if (wait_done) state <= ili_pkg::DISPLAY_ON;
                ili_pkg::DISPLAY_ON: if (fire) state <= ili_pkg::WAIT_ON;
                ili_pkg::WAIT_ON:    if (wait_done) state <= ili_pkg::SET_ROTATION;
                ili_pkg::SET_ROTATION: begin
                    if (fire) begin
                        if (step[0]) begin
                            step  <= '0;
                            state <= ili_pkg::SET_WINDOW;
                        end else begin
                            step <= step + IDX_W'(1);
                        end
                    end
                end
                ili_pkg::SET_WINDOW: begin
                    if (fire) begin
                        if (step == IDX_W'(10)) begin // RAMWR just sent
                            step  <= '0;
                            state <= ili_pkg::PIXEL_HIGH;
                        end else begin
                            step <= step + IDX_W'(1);
                        end
                    end
                end
                ili_pkg::PIXEL_HIGH: if (fire) state <= ili_pkg::PIXEL_LOW;
                ili_pkg::PIXEL_LOW: begin
                    if (fire) begin
                        state <= frame_done ? ili_pkg::FRAME_PAUSE : ili_pkg::PIXEL_HIGH;
                    end
                end
                ili_pkg::FRAME_PAUSE: if (!frame_done) state <= ili_pkg::PIXEL_HIGH;
                default:              state <= ili_pkg::START;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_send_taken: assert property (@(posedge clk) disable iff (!rst)
        word_bus.send |-> word_bus.idle ##1 !word_bus.idle);

    a_data_clk_high: assert property (@(posedge clk) disable iff (!rst)
        data_clk |-> state == ili_pkg::PIXEL_HIGH ##1 state == ili_pkg::PIXEL_LOW);

endmodule

//--- logic/ili9341_controller.sv
`timescale 1ns/100ps
`include "ili_consts.svh"

module ili9341_controller #(
    parameter int unsigned wait_cycles = `ILI_WAIT_100MS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ILI_PIXEL_W-1:0] input_data,
    input  logic                    frame_done,
    output logic                    spi_mosi,
    output logic                    spi_sck,
    output logic                    spi_cs,
    output logic                    spi_dc,
    output logic                    data_clk
);

    ili_word_if word_bus ();    // Sequencer to SPI master

    ili_sequencer #(
        .wait_cycles (wait_cycles)
    ) ili_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .input_data (input_data),
        .frame_done (frame_done),
        .data_clk   (data_clk),
        .word_bus   (word_bus.source)
    );

    ili_spi_master ili_spi_master_i (
        .clk      (clk),
        .rst      (rst),
        .spi_mosi (spi_mosi),
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_dc   (spi_dc),
        .word_bus (word_bus.sink)
    );

endmodule

//--- sim/ili_lcd_monitor.sv
`timescale 1ns/100ps

module ili_lcd_monitor (
    input  logic        clk,
    input  logic        rst,
    input  logic        spi_mosi,
    input  logic        spi_sck,
    input  logic        spi_cs,
    input  logic        spi_dc,
    output logic        word_valid,     // One clk per decoded word
    output logic [8:0]  word,           // {dc, byte}
    output logic [31:0] gap             // cs high cycles before the word
);

    logic        sck_d;
    logic        cs_d;
    logic [2:0]  nbits;
    logic [6:0]  shift;
    logic [31:0] gap_cnt;
    logic [31:0] gap_q;

    // A bit is taken on the clk edge that first sees sck high
    always @(posedge clk) begin
        word_valid <= 1'b0;
        sck_d      <= spi_sck;
        cs_d       <= spi_cs;
        if (!rst) begin
            nbits   <= '0;
            gap_cnt <= '0;
        end else if (spi_cs) begin
            nbits   <= '0;
            gap_cnt <= gap_cnt + 32'd1;
        end else begin
            if (cs_d) begin
                gap_q   <= gap_cnt;     // Start of a word
                gap_cnt <= '0;
            end
            if (spi_sck && !sck_d) begin
                shift <= {shift[5:0], spi_mosi};
                nbits <= nbits + 3'd1;
                if (nbits == 3'd7) begin
                    word_valid <= 1'b1;
                    word       <= {spi_dc, shift, spi_mosi};
                    gap        <= gap_q;
                end
            end
        end
    end

endmodule

//--- sim/tb_ili9341.sv
`timescale 1ns/100ps
`include "ili_consts.svh"

module tb_ili9341;

    localparam int WAIT_CYC  = 200;
    localparam int NUM_PIX   = 60;
    localparam int CLK_NS    = 100;
    localparam int PIX_BASE  = 98;              // Index of the first pixel word
    localparam int WD_CYCLES = 3 * WAIT_CYC + 120 * 20 + NUM_PIX * 60;

    logic                    clk;
    logic                    rst;
    logic [`ILI_PIXEL_W-1:0] input_data;
    logic                    frame_done;
    logic                    spi_mosi;
    logic                    spi_sck;
    logic                    spi_cs;
    logic                    spi_dc;
    logic                    data_clk;
    logic                    mon_valid;
    logic [8:0]              mon_word;
    logic [31:0]             mon_gap;

    // Rotation, column window, page window and memory write
    logic [8:0]  setup_q [$] = '{9'h036, 9'h148, 9'h02A, 9'h100, 9'h100, 9'h100, 9'h1EF,
                                 9'h02B, 9'h100, 9'h100, 9'h101, 9'h13F, 9'h02C};
    logic [15:0] pix_q [$];                     // Pixels taken at data_clk
    logic [15:0] cur_pix = '0;
    int          errs [$] = '{0, 0, 0, 0, 0, 0, 0};
    int          n_words = 0;
    int          pauses = 0;
    bit          started = 1'b0;
    bit          done = 1'b0;
    bit          cs_d = 1'b1;
    bit          fd_d = 1'b0;
    bit          pause_armed = 1'b0;            // Low byte sent with frame_done high

    ili9341_controller #(
        .wait_cycles (WAIT_CYC)
    ) ili9341_controller_i (
        .clk        (clk),
        .rst        (rst),
        .input_data (input_data),
        .frame_done (frame_done),
        .spi_mosi   (spi_mosi),
        .spi_sck    (spi_sck),
        .spi_cs     (spi_cs),
        .spi_dc     (spi_dc),
        .data_clk   (data_clk)
    );

    ili_lcd_monitor ili_lcd_monitor_i (
        .clk        (clk),
        .rst        (rst),
        .spi_mosi   (spi_mosi),
        .spi_sck    (spi_sck),
        .spi_cs     (spi_cs),
        .spi_dc     (spi_dc),
        .word_valid (mon_valid),
        .word       (mon_word),
        .gap        (mon_gap)
    );

    task automatic show_mismatch(input int t, input string name, input logic [8:0] got,
                                 input logic [8:0] want);
        $display("FAILED %s: got 0x%03h, expected 0x%03h", name, got, want);
        errs[t]++;
    endtask

    task automatic note_problem(input int t, input string what);
        $display("Test %0d error: %s", t, what);
        errs[t]++;
    endtask

    task automatic close_test(input int t, input string name);
        if (errs[t] == 0) begin
            $display("Test %0d %s: passed", t, name);
        end else begin
            $display("Test %0d %s: %0d errors", t, name, errs[t]);
        end
    endtask

    // ------------------------------------------------------------
    // Expected word sequence
    // ------------------------------------------------------------
    task automatic check_word();
        string      name;
        logic [8:0] want;
        name = $sformatf("spi word %0d", n_words);
        if (n_words == 0) begin
            if (mon_word !== 9'h001) show_mismatch(2, name, mon_word, 9'h001);
        end else if (n_words == 1) begin
            if (mon_word !== 9'h0CB) show_mismatch(2, name, mon_word, 9'h0CB);
            if (mon_gap < WAIT_CYC) note_problem(2, "delay after software reset too short");
            close_test(2, "software reset and delay");
        end else if (n_words <= 83) begin
            if (mon_gap >= WAIT_CYC) note_problem(3, {"delay inside the table at ", name});
            if (n_words == 83 && mon_word !== 9'h011) show_mismatch(3, name, mon_word, 9'h011);
        end else if (n_words == 84) begin
            if (mon_word !== 9'h029) show_mismatch(3, name, mon_word, 9'h029);
            if (mon_gap < WAIT_CYC) note_problem(3, "delay after sleep out too short");
        end else if (n_words < PIX_BASE) begin
            if (n_words == 85) begin
                if (mon_gap < WAIT_CYC) note_problem(3, "delay after display on too short");
                close_test(3, "init table and display on");
            end
            want = setup_q.pop_front();
            if (mon_word !== want) show_mismatch(4, name, mon_word, want);
            if (n_words == PIX_BASE - 1) close_test(4, "rotation, window and memory write");
        end else if ((n_words - PIX_BASE) % 2 == 0) begin
            if (pix_q.size() != 1) begin
                note_problem(5, $sformatf("%0d data_clk pulses for the pixel at %s",
                                          pix_q.size(), name));
            end
            if (pix_q.size() != 0) cur_pix = pix_q.pop_front();
            want = {1'b1, cur_pix[15:8]};       // High byte first
            if (mon_word !== want) show_mismatch(5, name, mon_word, want);
        end else begin
            want = {1'b1, cur_pix[7:0]};
            if (mon_word !== want) show_mismatch(5, name, mon_word, want);
        end
        n_words++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WD_CYCLES * CLK_NS);
        $display("Timeout: the pixel stream did not finish within %0d cycles", WD_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // Random pixels and frame_done pauses
    // ------------------------------------------------------------
    initial begin
        int pause_left;
        void'($urandom(32'h6185));
        pause_left = 0;
        input_data = '0;
        frame_done = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            input_data = 16'($urandom);
            if (pause_left > 0) begin
                frame_done = 1'b1;
                pause_left--;
            end else begin
                frame_done = 1'b0;
                if ($urandom % 32 == 0) pause_left = int'($urandom % 41);
            end
        end
    end

    always @(posedge clk) begin
        if (rst === 1'b1 && !started) begin
            if (spi_sck !== 1'b0) show_mismatch(1, "spi_sck", {8'h00, spi_sck}, 9'h000);
            if (data_clk !== 1'b0) show_mismatch(1, "data_clk", {8'h00, data_clk}, 9'h000);
            if (spi_cs !== 1'b1) begin
                // cs must have been high up to the first word
                if (!cs_d) show_mismatch(1, "spi_cs", {8'h00, cs_d}, 9'h001);
                started = 1'b1;                 // First word begins
                close_test(1, "idle levels after reset");
            end
        end
        if (rst === 1'b1) begin
            if (spi_cs === 1'b0 && cs_d) begin
                if (pause_armed) begin
                    note_problem(6, $sformatf("word %0d started while frame_done was high",
                                              n_words));
                end
                // fd_d is frame_done as seen on the send edge
                if (fd_d && n_words >= PIX_BASE && (n_words - PIX_BASE) % 2 == 1) begin
                    pause_armed = 1'b1;
                    pauses++;
                end
            end
            if (frame_done === 1'b0) pause_armed = 1'b0;
            if (mon_valid === 1'b1) check_word();
            if (data_clk === 1'b1) pix_q.push_back(input_data);
            if (n_words == PIX_BASE + 2 * NUM_PIX && !done) begin
                close_test(5, "pixel stream");
                if (pauses == 0) note_problem(6, "no frame pause was exercised");
                close_test(6, "frame pause");
                done = 1'b1;
            end
        end
        cs_d = spi_cs;
        fd_d = frame_done;
    end

    initial begin
        int failed;
        failed = 0;
        rst    = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b1;
        wait (done);
        foreach (errs[i]) begin
            if (errs[i] != 0) failed++;
        end
        $display("Tests run 6, passed %0d, failed %0d", 6 - failed, failed);
        if (failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
logic/ili_pkg.sv
logic/ili_word_if.sv
logic/ili_init_rom.sv
logic/ili_spi_master.sv
logic/ili_sequencer.sv
logic/ili9341_controller.sv
sim/ili_lcd_monitor.sv
sim/tb_ili9341.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ili9341
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
